//--- Bender.yml
package:
  name: core

sources:
  - include_dirs:
      - include
    files:
      - logic/cpuIsaPkg.sv
      - logic/cpuCtrlPkg.sv
      - logic/phaseSequencer.sv
      - logic/instructionDecoder.sv
      - logic/registerFile.sv
      - logic/fullAlu.sv
      - logic/programCounter.sv
      - logic/busController.sv
      - logic/core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/coreTb.sv

//--- compile.f
+incdir+include
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/phaseSequencer.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/fullAlu.sv
logic/programCounter.sv
logic/busController.sv
logic/core.sv
sim/coreTb.sv

//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of the data path, the external bus and every register.
`define DATA_WIDTH 16

// Register file geometry.
`define REG_COUNT 8
`define REG_ADDR_WIDTH 3 // Enough to select one of REG_COUNT registers.

// Address of the first fetch after reset.
`define RESET_VECTOR 16'h0000

// Bytes per instruction word.
// The bus is byte addressed and a word is always two bytes.
`define PC_STEP 16'd2

`endif

//--- logic/busController.sv
`default_nettype none

`include "cpu_consts.svh"

module busController (
	input wire clk,
	input wire rstN,
	input wire fetch,
	input wire execute,
	input wire memRead,
	input wire memWrite,
	input wire cpuCtrlPkg::addrSelT addrSel,
	input wire [`DATA_WIDTH-1:0] pc,
	input wire [`DATA_WIDTH-1:0] regAData,
	input wire [`DATA_WIDTH-1:0] regBData,
	input wire [`DATA_WIDTH-1:0] din,
	output logic [`DATA_WIDTH-1:0] addr,
	output logic [`DATA_WIDTH-1:0] dout,
	output logic rdN,
	output logic wrN,
	output logic [`DATA_WIDTH-1:0] memData
);

	// Fetch always reads at the PC.
	assign addr = (fetch || addrSel == cpuCtrlPkg::ADDR_PC) ? pc : regBData;
	assign dout = regAData; // Store data.

	// Strobes last exactly one phase.
	assign rdN = ~(fetch || (execute && memRead));
	assign wrN = ~(execute && memWrite);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memData <= '0;
		end else if (execute && memRead) begin
			memData <= din; // Written back in commit.
		end
	end

endmodule

`default_nettype wire

//--- logic/core.sv
`default_nettype none

`include "cpu_consts.svh"

module core (
	input wire clk,
	input wire rstN,
	input wire [`DATA_WIDTH-1:0] din,
	output logic [`DATA_WIDTH-1:0] addr,
	output logic [`DATA_WIDTH-1:0] dout,
	output logic rdN,
	output logic wrN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic stopped
);

	cpuIsaPkg::aluOpT aluOp;
	logic [`REG_ADDR_WIDTH-1:0] regA;
	logic [`REG_ADDR_WIDTH-1:0] regB;
	logic regWrite;
	cpuCtrlPkg::wbSelT wbSel;
	logic ccWrite;
	logic memRead;
	logic memWrite;
	cpuCtrlPkg::addrSelT addrSel;
	cpuCtrlPkg::pcSelT pcSel;
	logic [7:0] branchOffset;
	logic halt;

	logic [`DATA_WIDTH-1:0] regAData;
	logic [`DATA_WIDTH-1:0] regBData;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] memData;
	logic [`DATA_WIDTH-1:0] pc;
	logic ccZero;
	logic ccCarry;
	logic ccSign;

	phaseSequencer phaseSequencerInst (
		.clk(clk),
		.rstN(rstN),
		.halt(halt),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.stopped(stopped)
	);

	// Instruction latch and group decoding.
	instructionDecoder instructionDecoderInst (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.din(din),
		.zero(ccZero),
		.carry(ccCarry),
		.sign(ccSign),
		.aluOp(aluOp),
		.regA(regA),
		.regB(regB),
		.regWrite(regWrite),
		.wbSel(wbSel),
		.ccWrite(ccWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.addrSel(addrSel),
		.pcSel(pcSel),
		.branchOffset(branchOffset),
		.halt(halt)
	);

	registerFile registerFileInst (
		.clk(clk),
		.rstN(rstN),
		.commit(commit),
		.regWrite(regWrite),
		.regA(regA),
		.regB(regB),
		.wbSel(wbSel),
		.aluResult(aluResult),
		.memData(memData),
		.regAData(regAData),
		.regBData(regBData)
	);

	// Parity is kept in the flags but no condition tests it.
	fullAlu fullAluInst (
		.clk(clk),
		.rstN(rstN),
		.commit(commit),
		.ccWrite(ccWrite),
		.aluOp(aluOp),
		.a(regAData),
		.b(regBData),
		.result(aluResult),
		.zero(ccZero),
		.carry(ccCarry),
		.sign(ccSign),
		.parity()
	);

	programCounter programCounterInst (
		.clk(clk),
		.rstN(rstN),
		.decode(decode),
		.commit(commit),
		.pcSel(pcSel),
		.branchOffset(branchOffset),
		.pc(pc)
	);

	busController busControllerInst (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.execute(execute),
		.memRead(memRead),
		.memWrite(memWrite),
		.addrSel(addrSel),
		.pc(pc),
		.regAData(regAData),
		.regBData(regBData),
		.din(din),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wrN(wrN),
		.memData(memData)
	);

endmodule

`default_nettype wire

//--- logic/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

	// One bit per phase.
	typedef enum logic [4:0] {
		PHASE_STOPPED = 5'b00001,
		PHASE_FETCH   = 5'b00010,
		PHASE_DECODE  = 5'b00100,
		PHASE_EXECUTE = 5'b01000,
		PHASE_COMMIT  = 5'b10000
	} phaseT;

	// Source of the register file write data.
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wbSelT;

	// Address used in execute.
	typedef enum logic {
		ADDR_REGB = 1'b0,
		ADDR_PC   = 1'b1
	} addrSelT;

	// PC change at commit, on top of the step made in decode.
	typedef enum logic [1:0] {
		PC_SEL_STEP   = 2'd0, // No further change.
		PC_SEL_BRANCH = 2'd1,
		PC_SEL_SKIP   = 2'd2  // Steps over an immediate word.
	} pcSelT;

endpackage

`default_nettype wire

//--- logic/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// Top two bits of every instruction.
	typedef enum logic [1:0] {
		GROUP_ALU       = 2'd0,
		GROUP_LOADSTORE = 2'd1,
		GROUP_JUMP      = 2'd2,
		GROUP_GENERAL   = 2'd3
	} groupT;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_ADC = 4'd1,
		ALU_SUB = 4'd2,
		ALU_SBC = 4'd3,
		ALU_AND = 4'd4,
		ALU_OR  = 4'd5,
		ALU_XOR = 4'd6,
		ALU_NOT = 4'd7,
		ALU_SHL = 4'd8,
		ALU_SHR = 4'd9,
		ALU_MOV = 4'd10,
		ALU_CMP = 4'd11 // Subtract for flags only.
	} aluOpT;

	// Carried in the low two opcode bits.
	typedef enum logic [1:0] {
		MEM_LOAD    = 2'd0,
		MEM_STORE   = 2'd1,
		MEM_LOADIMM = 2'd2
	} memOpT;

	typedef enum logic [1:0] {
		COND_ALWAYS = 2'd0,
		COND_ZERO   = 2'd1,
		COND_CARRY  = 2'd2,
		COND_SIGN   = 2'd3
	} condT;

	typedef enum logic {
		GEN_NOP  = 1'b0,
		GEN_HALT = 1'b1
	} generalOpT;

	// Used by the ALU, load/store and general groups.
	typedef struct packed {
		groupT group;
		logic [3:0] opcode;
		logic [2:0] regA; // Destination, and store data.
		logic [2:0] regB; // Second operand, or memory address.
		logic [3:0] spare;
	} regViewT;

	typedef struct packed {
		groupT group;
		condT cond;
		logic negate; // Inverts the condition test.
		logic [2:0] spare;
		logic [7:0] offset; // Signed, in words.
	} branchViewT;

	typedef union packed {
		regViewT regView;
		branchViewT branchView;
	} instrT;

endpackage

`default_nettype wire

//--- logic/fullAlu.sv
`default_nettype none

`include "cpu_consts.svh"

module fullAlu (
	input wire clk,
	input wire rstN,
	input wire commit,
	input wire ccWrite,
	input wire cpuIsaPkg::aluOpT aluOp,
	input wire [`DATA_WIDTH-1:0] a,
	input wire [`DATA_WIDTH-1:0] b,
	output logic [`DATA_WIDTH-1:0] result,
	output logic zero,
	output logic carry,
	output logic sign,
	output logic parity
);

	logic carryOut; // Carry or borrow of the current operation.
	logic [`DATA_WIDTH:0] carryIn;

	assign carryIn = {{`DATA_WIDTH{1'b0}}, carry};

	always_comb begin
		carryOut = 1'b0; // Logic ops and moves clear carry.
		result = '0;
		case (aluOp)
			cpuIsaPkg::ALU_ADD: {carryOut, result} = {1'b0, a} + {1'b0, b};
			cpuIsaPkg::ALU_ADC: {carryOut, result} = {1'b0, a} + {1'b0, b} + carryIn;
			cpuIsaPkg::ALU_SUB,
			cpuIsaPkg::ALU_CMP: {carryOut, result} = {1'b0, a} - {1'b0, b};
			cpuIsaPkg::ALU_SBC: {carryOut, result} = {1'b0, a} - {1'b0, b} - carryIn;
			cpuIsaPkg::ALU_AND: result = a & b;
			cpuIsaPkg::ALU_OR: result = a | b;
			cpuIsaPkg::ALU_XOR: result = a ^ b;
			cpuIsaPkg::ALU_NOT: result = ~b;
			cpuIsaPkg::ALU_SHL: {carryOut, result} = {a, 1'b0}; // Top bit out to carry.
			cpuIsaPkg::ALU_SHR: {result, carryOut} = {1'b0, a};
			cpuIsaPkg::ALU_MOV: result = b;
			default: ;
		endcase
	end

	// Condition codes change only at the end of commit.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			zero <= 1'b0;
			carry <= 1'b0;
			sign <= 1'b0;
			parity <= 1'b0;
		end else if (commit && ccWrite) begin
			zero <= (result == '0);
			carry <= carryOut;
			sign <= result[`DATA_WIDTH-1];
			parity <= ~^result; // Set on even parity.
		end
	end

endmodule

`default_nettype wire

//--- logic/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
	input wire clk,
	input wire rstN,
	input wire fetch,
	input wire [15:0] din,
	input wire zero,
	input wire carry,
	input wire sign,
	output cpuIsaPkg::aluOpT aluOp,
	output logic [2:0] regA,
	output logic [2:0] regB,
	output logic regWrite,
	output cpuCtrlPkg::wbSelT wbSel,
	output logic ccWrite,
	output logic memRead,
	output logic memWrite,
	output cpuCtrlPkg::addrSelT addrSel,
	output cpuCtrlPkg::pcSelT pcSel,
	output logic [7:0] branchOffset,
	output logic halt
);

	cpuIsaPkg::instrT instr;
	logic condMet; // Selected flag, before the negate bit.

	always_ff @(posedge clk) begin
		if (!rstN) begin
			instr <= {cpuIsaPkg::GROUP_GENERAL, 14'h0000}; // NOP.
		end else if (fetch) begin
			instr <= din;
		end
	end

	always_comb begin
		case (instr.branchView.cond)
			cpuIsaPkg::COND_ALWAYS: condMet = 1'b1;
			cpuIsaPkg::COND_ZERO: condMet = zero;
			cpuIsaPkg::COND_CARRY: condMet = carry;
			default: condMet = sign;
		endcase
	end

	assign regA = instr.regView.regA;
	assign regB = instr.regView.regB;
	assign branchOffset = instr.branchView.offset;

	always_comb begin
		aluOp = cpuIsaPkg::ALU_ADD;
		regWrite = 1'b0;
		wbSel = cpuCtrlPkg::WB_ALU;
		ccWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		addrSel = cpuCtrlPkg::ADDR_REGB;
		pcSel = cpuCtrlPkg::PC_SEL_STEP;
		halt = 1'b0;
		case (instr.regView.group)
			cpuIsaPkg::GROUP_ALU: begin
				aluOp = cpuIsaPkg::aluOpT'(instr.regView.opcode);
				regWrite = (aluOp != cpuIsaPkg::ALU_CMP); // CMP only sets flags.
				ccWrite = 1'b1;
			end
			cpuIsaPkg::GROUP_LOADSTORE: begin
				case (cpuIsaPkg::memOpT'(instr.regView.opcode[1:0]))
					cpuIsaPkg::MEM_LOAD: begin
						memRead = 1'b1;
						regWrite = 1'b1;
						wbSel = cpuCtrlPkg::WB_MEM;
					end
					cpuIsaPkg::MEM_STORE: memWrite = 1'b1;
					cpuIsaPkg::MEM_LOADIMM: begin
						memRead = 1'b1;
						regWrite = 1'b1;
						wbSel = cpuCtrlPkg::WB_MEM;
						addrSel = cpuCtrlPkg::ADDR_PC; // PC already points at the immediate.
						pcSel = cpuCtrlPkg::PC_SEL_SKIP;
					end
					default: ;
				endcase
			end
			cpuIsaPkg::GROUP_JUMP: begin
				if (condMet ^ instr.branchView.negate) begin
					pcSel = cpuCtrlPkg::PC_SEL_BRANCH;
				end
			end
			default: begin
				halt = (cpuIsaPkg::generalOpT'(instr.regView.opcode[0]) == cpuIsaPkg::GEN_HALT);
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/phaseSequencer.sv
`default_nettype none

module phaseSequencer (
	input wire clk,
	input wire rstN,
	input wire halt,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic stopped
);

	cpuCtrlPkg::phaseT state;
	cpuCtrlPkg::phaseT nextState;

	always_comb begin
		case (state)
			cpuCtrlPkg::PHASE_FETCH: nextState = cpuCtrlPkg::PHASE_DECODE;
			cpuCtrlPkg::PHASE_DECODE: nextState = cpuCtrlPkg::PHASE_EXECUTE;
			cpuCtrlPkg::PHASE_EXECUTE: nextState = cpuCtrlPkg::PHASE_COMMIT;
			cpuCtrlPkg::PHASE_COMMIT: begin
				// Halt only counts in a real commit phase.
				nextState = (commit && halt) ? cpuCtrlPkg::PHASE_STOPPED
					: cpuCtrlPkg::PHASE_FETCH;
			end
			default: nextState = cpuCtrlPkg::PHASE_STOPPED; // Held until reset.
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= cpuCtrlPkg::PHASE_COMMIT; // So the first phase out of reset is fetch.
			fetch <= 1'b0;
			decode <= 1'b0;
			execute <= 1'b0;
			commit <= 1'b0;
			stopped <= 1'b0;
		end else begin
			state <= nextState;
			fetch <= (nextState == cpuCtrlPkg::PHASE_FETCH);
			decode <= (nextState == cpuCtrlPkg::PHASE_DECODE);
			execute <= (nextState == cpuCtrlPkg::PHASE_EXECUTE);
			commit <= (nextState == cpuCtrlPkg::PHASE_COMMIT);
			stopped <= (nextState == cpuCtrlPkg::PHASE_STOPPED);
		end
	end

endmodule

`default_nettype wire

//--- logic/programCounter.sv
`default_nettype none

`include "cpu_consts.svh"

module programCounter (
	input wire clk,
	input wire rstN,
	input wire decode,
	input wire commit,
	input wire cpuCtrlPkg::pcSelT pcSel,
	input wire [7:0] branchOffset,
	output logic [`DATA_WIDTH-1:0] pc
);

	logic [`DATA_WIDTH-1:0] branchDisp; // Word offset as a byte displacement.

	assign branchDisp = {{(`DATA_WIDTH - 9){branchOffset[7]}}, branchOffset, 1'b0};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_VECTOR;
		end else if (decode) begin
			pc <= pc + `PC_STEP; // Now points past the instruction.
		end else if (commit) begin
			case (pcSel)
				cpuCtrlPkg::PC_SEL_BRANCH: pc <= pc + branchDisp;
				cpuCtrlPkg::PC_SEL_SKIP: pc <= pc + `PC_STEP;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`default_nettype none

`include "cpu_consts.svh"

module registerFile (
	input wire clk,
	input wire rstN,
	input wire commit,
	input wire regWrite,
	input wire [`REG_ADDR_WIDTH-1:0] regA,
	input wire [`REG_ADDR_WIDTH-1:0] regB,
	input wire cpuCtrlPkg::wbSelT wbSel,
	input wire [`DATA_WIDTH-1:0] aluResult,
	input wire [`DATA_WIDTH-1:0] memData,
	output logic [`DATA_WIDTH-1:0] regAData,
	output logic [`DATA_WIDTH-1:0] regBData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Both read ports are asynchronous.
	assign regAData = regs[regA];
	assign regBData = regs[regB];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && regWrite) begin
			regs[regA] <= (wbSel == cpuCtrlPkg::WB_MEM) ? memData : aluResult;
		end
	end

endmodule

`default_nettype wire

//--- sim/coreTb.sv
`default_nettype none

`include "cpu_consts.svh"

module coreTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 16;
	localparam int IdleCycles = 8; // Watched after halt.
	localparam int NopCount = 6;
	localparam logic [15:0] MarkerWord = 16'h600d;

	// Executed instructions per test, jump test taken at its longest path.
	localparam int ProgramInstrs = 7 + 24 + 61 + 54 + 13;
	localparam int NumTests = 5;
	localparam int BudgetCycles = ProgramInstrs * 4 + NumTests * (ResetCycles + IdleCycles + 4);

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic [`DATA_WIDTH-1:0] din;
	logic [`DATA_WIDTH-1:0] addr;
	logic [`DATA_WIDTH-1:0] dout;
	logic rdN;
	logic wrN;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic stopped;

	logic [15:0] mem [256];
	logic [31:0] lfsr = 32'hd4a5d8ac;
	int progPtr; // Next word to load.
	logic [15:0] expFetch [$];
	logic [15:0] fetchAddrs [$];
	int fetchCycles [$];
	int cycleCount = 0;
	int lastPhase = 0; // 0 none, then fetch to stopped as 1 to 5.
	logic prevRstN;
	bit markerExp [$];
	int flagInstrs;
	int valueErrors = 0;
	int protocolErrors = 0;

	core dut0 (
		.clk(clk),
		.rstN(rstN),
		.din(din),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wrN(wrN),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.stopped(stopped)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// Zero-wait memory, word index from address bits 8:1.
	assign din = (rdN === 1'b0) ? mem[addr[8:1]] : 16'h0000;

	always @(posedge clk) begin
		if (wrN === 1'b0) begin
			mem[addr[8:1]] <= dout;
		end
	end

	task automatic wrongValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("** Error at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
		valueErrors++;
	endtask

	task automatic protocolError(input string what);
		$display("** Error at %0t ns: %s", $time, what);
		protocolErrors++;
	endtask

	function automatic bit phaseFollows(input int last, input int next);
		case (next)
			1: return last == 0 || last == 4;
			5: return last == 4 || last == 5; // Stopped holds until reset.
			default: return last == next - 1;
		endcase
	endfunction

	// Phase order, strobes and fetch addresses, sampled before each edge.
	always @(posedge clk) begin : busMonitor
		logic [4:0] strobes;
		int phase;
		strobes = {stopped, commit, execute, decode, fetch};
		cycleCount++;
		if (rstN !== 1'b1) begin
			if (prevRstN === 1'b0 && (rdN !== 1'b1 || wrN !== 1'b1 || strobes !== 5'b0)) begin
				protocolError("a strobe is active during reset");
			end
			lastPhase = 0;
		end else if (strobes == 5'b0) begin
			if (lastPhase != 0) protocolError("no phase strobe is active");
		end else if ($countones(strobes) != 1) begin
			protocolError("more than one phase strobe is active");
		end else begin
			phase = fetch ? 1 : decode ? 2 : execute ? 3 : commit ? 4 : 5;
			if (!phaseFollows(lastPhase, phase)) begin
				protocolError($sformatf("phase %0d follows phase %0d", phase, lastPhase));
			end
			if (fetch) begin
				if (rdN !== 1'b0) protocolError("rdN is high during fetch");
				if (lastPhase == 0 && addr !== `RESET_VECTOR) begin
					wrongValue("first fetch address", addr, `RESET_VECTOR);
				end
				fetchAddrs.push_back(addr);
				fetchCycles.push_back(cycleCount);
			end
			if (stopped && (rdN !== 1'b1 || wrN !== 1'b1)) begin
				protocolError("a bus strobe is active while stopped");
			end
			lastPhase = phase;
		end
		prevRstN = rstN;
	end

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randWord(output logic [15:0] w);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsrStep(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	function automatic logic [15:0] fillWord(input int i);
		return {8'(i) ^ 8'ha5, 8'(i)};
	endfunction

	// Instruction encoders.
	function automatic logic [15:0] regWord(input logic [1:0] group, input logic [3:0] opcode,
			input int ra, input int rb);
		return {group, opcode, 3'(ra), 3'(rb), 4'h0};
	endfunction

	task automatic putInstr(input logic [15:0] w);
		mem[progPtr] <= w;
		expFetch.push_back(16'(progPtr * 2));
		progPtr++;
	endtask

	task automatic loadImm(input int ra, input logic [15:0] value);
		putInstr(regWord(cpuIsaPkg::GROUP_LOADSTORE, {2'b00, cpuIsaPkg::MEM_LOADIMM}, ra, 0));
		mem[progPtr] <= value; // Immediate word, never fetched.
		progPtr++;
	endtask

	task automatic load(input int ra, input int rb);
		putInstr(regWord(cpuIsaPkg::GROUP_LOADSTORE, {2'b00, cpuIsaPkg::MEM_LOAD}, ra, rb));
	endtask

	task automatic store(input int ra, input int rb);
		putInstr(regWord(cpuIsaPkg::GROUP_LOADSTORE, {2'b00, cpuIsaPkg::MEM_STORE}, ra, rb));
	endtask

	task automatic alu(input cpuIsaPkg::aluOpT op, input int ra, input int rb);
		putInstr(regWord(cpuIsaPkg::GROUP_ALU, op, ra, rb));
	endtask

	task automatic jump(input cpuIsaPkg::condT cond, input bit negate, input logic [7:0] offset);
		putInstr({cpuIsaPkg::GROUP_JUMP, cond, negate, 3'b000, offset});
	endtask

	task automatic general(input cpuIsaPkg::generalOpT op);
		putInstr(regWord(cpuIsaPkg::GROUP_GENERAL, {3'b000, op}, 0, 0));
	endtask

	// Reference ALU, returns {carry, result}.
	function automatic logic [16:0] aluModel(input cpuIsaPkg::aluOpT op, input logic [15:0] a,
			input logic [15:0] b, input logic cin);
		case (op)
			cpuIsaPkg::ALU_ADD: return 17'(a) + 17'(b);
			cpuIsaPkg::ALU_ADC: return 17'(a) + 17'(b) + 17'(cin);
			cpuIsaPkg::ALU_SUB, cpuIsaPkg::ALU_CMP: return {a < b, a - b};
			cpuIsaPkg::ALU_SBC: return {17'(a) < 17'(b) + 17'(cin), a - b - {15'd0, cin}};
			cpuIsaPkg::ALU_AND: return {1'b0, a & b};
			cpuIsaPkg::ALU_OR: return {1'b0, a | b};
			cpuIsaPkg::ALU_XOR: return {1'b0, a ^ b};
			cpuIsaPkg::ALU_NOT: return {1'b0, ~b};
			cpuIsaPkg::ALU_SHL: return {a[15], a[14:0], 1'b0};
			cpuIsaPkg::ALU_SHR: return {a[0], 1'b0, a[15:1]};
			default: return {1'b0, b}; // MOV.
		endcase
	endfunction

	function automatic bit condHolds(input cpuIsaPkg::condT cond, input bit z, input bit c,
			input bit s);
		case (cond)
			cpuIsaPkg::COND_ALWAYS: return 1'b1;
			cpuIsaPkg::COND_ZERO: return z;
			cpuIsaPkg::COND_CARRY: return c;
			default: return s;
		endcase
	endfunction

	// Holds the core in reset while a fresh memory image is loaded.
	task automatic startTest();
		@(posedge clk);
		rstN <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] <= fillWord(i);
		end
		progPtr = 0;
		expFetch.delete();
		fetchAddrs.delete();
		fetchCycles.delete();
	endtask

	task automatic runToHalt();
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
		while (stopped !== 1'b1) @(posedge clk);
		repeat (IdleCycles) @(posedge clk);
	endtask

	task automatic checkFetches();
		if (fetchAddrs.size() != expFetch.size()) begin
			wrongValue("fetch count", fetchAddrs.size(), expFetch.size());
		end else begin
			for (int i = 0; i < expFetch.size(); i++) begin
				if (fetchAddrs[i] !== expFetch[i]) begin
					wrongValue($sformatf("fetch %0d address", i), fetchAddrs[i], expFetch[i]);
				end
				if (i > 0 && fetchCycles[i] - fetchCycles[i - 1] != 4) begin
					wrongValue($sformatf("fetch %0d spacing", i),
						fetchCycles[i] - fetchCycles[i - 1], 4);
				end
			end
		end
	endtask

	task automatic nopStreamTest();
		startTest();
		for (int i = 0; i < NopCount; i++) begin
			general(cpuIsaPkg::GEN_NOP);
		end
		general(cpuIsaPkg::GEN_HALT);
		runToHalt();
		checkFetches();
	endtask

	task automatic immediateStoreTest();
		logic [15:0] vals [7];
		startTest();
		for (int r = 0; r < 7; r++) begin
			randWord(vals[r]);
			loadImm(r, vals[r]);
		end
		for (int r = 0; r < 7; r++) begin
			loadImm(7, 16'h0100 + 16'(2 * r)); // R7 is the base.
			store(r, 7);
		end
		loadImm(7, 16'h0120);
		store(7, 7);
		general(cpuIsaPkg::GEN_HALT);
		runToHalt();
		checkFetches();
		for (int r = 0; r < 7; r++) begin
			if (mem[8'h80 + r] !== vals[r]) begin
				wrongValue($sformatf("stored r%0d", r), mem[8'h80 + r], vals[r]);
			end
		end
		if (mem[8'h90] !== 16'h0120) wrongValue("stored r7", mem[8'h90], 16'h0120);
	endtask

	task automatic aluOpsTest();
		logic [15:0] a;
		logic [15:0] b;
		logic [16:0] wide;
		logic [15:0] expResult [12];
		logic carryIn;
		cpuIsaPkg::aluOpT op;
		startTest();
		carryIn = 1'b0; // Flags are clear out of reset.
		for (int k = 0; k < 12; k++) begin
			op = cpuIsaPkg::aluOpT'(k);
			randWord(a);
			randWord(b);
			loadImm(1, a);
			loadImm(2, b);
			loadImm(3, 16'h0100 + 16'(2 * k));
			alu(op, 1, 2);
			store(1, 3);
			wide = aluModel(op, a, b, carryIn);
			carryIn = wide[16];
			expResult[k] = (op == cpuIsaPkg::ALU_CMP) ? a : wide[15:0];
		end
		general(cpuIsaPkg::GEN_HALT);
		runToHalt();
		checkFetches();
		for (int k = 0; k < 12; k++) begin
			op = cpuIsaPkg::aluOpT'(k);
			if (mem[8'h80 + k] !== expResult[k]) begin
				wrongValue($sformatf("%s result", op.name()), mem[8'h80 + k], expResult[k]);
			end
		end
	endtask

	// Sets flags, then a conditional jump decides whether the marker gets stored.
	task automatic flagCheck(input cpuIsaPkg::aluOpT op, input logic [15:0] a,
			input logic [15:0] b, input cpuIsaPkg::condT cond, input bit negate,
			input bit backward);
		logic [16:0] wide;
		bit taken;
		int back;
		wide = aluModel(op, a, b, 1'b0);
		taken = condHolds(cond, wide[15:0] == 16'h0000, wide[16], wide[15]) ^ negate;
		loadImm(6, 16'h0100 + 16'(2 * markerExp.size()));
		if (!backward) begin
			loadImm(1, a);
			loadImm(2, b);
			alu(op, 1, 2);
			jump(cond, negate, 8'd1); // Over the store.
			store(5, 6);
			flagInstrs += taken ? 5 : 6;
			markerExp.push_back(!taken);
		end else begin
			jump(cpuIsaPkg::COND_ALWAYS, 1'b0, 8'd2);
			back = progPtr;
			store(5, 6);
			jump(cpuIsaPkg::COND_ALWAYS, 1'b0, 8'd6); // Past the test jump.
			loadImm(1, a);
			loadImm(2, b);
			alu(op, 1, 2);
			jump(cond, negate, 8'(back - (progPtr + 1)));
			flagInstrs += taken ? 8 : 6;
			markerExp.push_back(taken);
		end
	endtask

	task automatic flagJumpTest();
		logic [15:0] exp;
		startTest();
		markerExp.delete();
		flagInstrs = 2;
		loadImm(5, MarkerWord);
		flagCheck(cpuIsaPkg::ALU_CMP, 16'h0005, 16'h0005, cpuIsaPkg::COND_ZERO, 1'b0, 1'b0);
		flagCheck(cpuIsaPkg::ALU_CMP, 16'h0005, 16'h0005, cpuIsaPkg::COND_ZERO, 1'b1, 1'b0);
		flagCheck(cpuIsaPkg::ALU_ADD, 16'hffff, 16'h0001, cpuIsaPkg::COND_CARRY, 1'b0, 1'b0);
		flagCheck(cpuIsaPkg::ALU_ADD, 16'h7000, 16'h1000, cpuIsaPkg::COND_SIGN, 1'b0, 1'b0);
		flagCheck(cpuIsaPkg::ALU_ADD, 16'h7000, 16'h1000, cpuIsaPkg::COND_CARRY, 1'b1, 1'b0);
		flagCheck(cpuIsaPkg::ALU_SHL, 16'h8001, 16'h0000, cpuIsaPkg::COND_CARRY, 1'b0, 1'b1);
		flagCheck(cpuIsaPkg::ALU_SHL, 16'h4000, 16'h0000, cpuIsaPkg::COND_SIGN, 1'b1, 1'b1);
		flagCheck(cpuIsaPkg::ALU_CMP, 16'h0003, 16'h0007, cpuIsaPkg::COND_ZERO, 1'b0, 1'b0);
		general(cpuIsaPkg::GEN_HALT);
		runToHalt();
		if (fetchAddrs.size() != flagInstrs) wrongValue("fetch count", fetchAddrs.size(), flagInstrs);
		for (int k = 0; k < markerExp.size(); k++) begin
			exp = markerExp[k] ? MarkerWord : fillWord(8'h80 + k);
			if (mem[8'h80 + k] !== exp) wrongValue($sformatf("marker %0d", k), mem[8'h80 + k], exp);
		end
	endtask

	task automatic loadHaltTest();
		logic [15:0] src [3];
		startTest();
		for (int i = 0; i < 3; i++) begin
			randWord(src[i]);
			mem[8'ha0 + i] <= src[i];
		end
		for (int i = 0; i < 3; i++) begin
			loadImm(1, 16'h0140 + 16'(2 * i));
			load(2, 1);
			loadImm(3, 16'h0180 + 16'(2 * i));
			store(2, 3);
		end
		general(cpuIsaPkg::GEN_HALT);
		runToHalt();
		checkFetches();
		for (int i = 0; i < 3; i++) begin
			if (mem[8'hc0 + i] !== src[i]) wrongValue($sformatf("copied word %0d", i), mem[8'hc0 + i], src[i]);
		end
		if (stopped !== 1'b1 || rdN !== 1'b1 || wrN !== 1'b1) begin
			protocolError("the core left the stopped state or drove a strobe after halt");
		end
	endtask

	initial begin
		nopStreamTest();
		immediateStoreTest();
		aluOpsTest();
		flagJumpTest();
		loadHaltTest();
		$display("Value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(BudgetCycles * ClkPeriod * 3 / 2);
		$display("Timeout: the core did not halt within %0d ns", BudgetCycles * ClkPeriod * 3 / 2);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
